/* calc_pkg.sv */
// Calculator data widths, operator codes, entry constants and FSM state types
package calc_pkg;

    localparam int DATA_W  = 16;
    localparam int DIGIT_W = 4;
    localparam int OP_W    = 3;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [DIGIT_W-1:0] digit_t;
    typedef logic [OP_W-1:0]    op_t;

    // One-hot operator keys
    localparam op_t OP_ADD = 3'b001;
    localparam op_t OP_SUB = 3'b010;
    localparam op_t OP_MUL = 3'b100;

    // Each new digit scales the running operand by ten
    localparam data_t DIGIT_BASE = DATA_W'(10);

    // Serial adder works a nibble at a time
    localparam int NIBBLE_W = 4;
    localparam int NIBBLES  = DATA_W / NIBBLE_W;
    localparam int PASS_W   = $clog2(NIBBLES);

    // One shift-and-add step per multiplier bit
    localparam int MULT_STEPS = DATA_W;
    localparam int STEP_W     = $clog2(MULT_STEPS);

    typedef enum logic [3:0] {
        ENTER_OP1,
        SCALE_OP1,
        ADD_DIGIT1,
        ENTER_OP2,
        SCALE_OP2,
        ADD_DIGIT2,
        START_CALC,
        WAIT_CALC,
        SHOW_RESULT
    } ctrl_state_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } mult_state_t;

endpackage

/* serial_add_sub.sv */
// Nibble-serial adder/subtractor with start/finish handshake
module serial_add_sub import calc_pkg::*; (
    input  logic  clk,
    input  logic  nRST,
    input  data_t a,
    input  data_t b,
    input  logic  sub,
    input  logic  start,
    output data_t sum,
    output logic  finish
);

    data_t             a_q;
    data_t             b_q;
    logic              carry;
    logic              running;
    logic [PASS_W-1:0] pass_cnt;
    logic [NIBBLE_W:0] nib_sum;

    // Lowest remaining nibble plus the carry from the previous pass
    assign nib_sum = {1'b0, a_q[NIBBLE_W-1:0]} + {1'b0, b_q[NIBBLE_W-1:0]}
                   + (NIBBLE_W+1)'(carry);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running  <= 1'b0;
            pass_cnt <= '0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start && !running) begin
                running  <= 1'b1;
                pass_cnt <= '0;
            end else if (running) begin
                pass_cnt <= pass_cnt + 1'b1;
                if (pass_cnt == PASS_W'(NIBBLES - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !running) begin
            // Two's complement subtract: inverted b and carry-in of one
            a_q   <= a;
            b_q   <= sub ? ~b : b;
            carry <= sub;
        end else if (running) begin
            a_q   <= a_q >> NIBBLE_W;
            b_q   <= b_q >> NIBBLE_W;
            carry <= nib_sum[NIBBLE_W];
            sum   <= {nib_sum[NIBBLE_W-1:0], sum[DATA_W-1:NIBBLE_W]};
        end
    end

endmodule

/* seq_multiplier.sv */
// Shift-and-add 16x16 multiplier returning the low 16 bits of the product
module seq_multiplier import calc_pkg::*; (
    input  logic  clk,
    input  logic  nRST,
    input  data_t a,
    input  data_t b,
    input  logic  start,
    output data_t product,
    output logic  finish
);

    mult_state_t       state;
    data_t             mcand;
    data_t             mplier;
    logic [STEP_W-1:0] step_cnt;

    assign finish = (state == DONE);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                    end
                end
                RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == STEP_W'(MULT_STEPS - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Multiplicand moves left, multiplier right, one bit per step
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            mcand   <= a;
            mplier  <= b;
            product <= '0;
        end else if (state == RUN) begin
            if (mplier[0]) begin
                // Upper bits fall off here, so the result wraps
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

/* calc_controller.sv */
// Keypad entry FSM driving the multiplier, the adder/subtractor and the display
module calc_controller import calc_pkg::*; (
    input  logic   clk,
    input  logic   nRST,
    input  digit_t keypad_input,
    input  logic   read_input,
    input  op_t    operator_input,
    input  logic   equal_input,
    input  data_t  mult_product,
    input  logic   mult_finish,
    input  data_t  addsub_sum,
    input  logic   addsub_finish,
    output data_t  mult_a,
    output data_t  mult_b,
    output logic   mult_start,
    output data_t  addsub_a,
    output data_t  addsub_b,
    output logic   addsub_sub,
    output logic   addsub_start,
    output data_t  display_output,
    output logic   complete,
    output logic   busy
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    data_t       operand1;
    data_t       operand2;
    digit_t      digit_q;
    op_t         op_q;
    logic        op_valid;
    logic        use_mult;
    logic        calc_done;
    data_t       digit_ext;
    data_t       entered;
    data_t       result;

    assign op_valid = (operator_input == OP_ADD) || (operator_input == OP_SUB)
                   || (operator_input == OP_MUL);
    assign use_mult  = (op_q == OP_MUL);
    assign calc_done = use_mult ? mult_finish : addsub_finish;
    assign result    = use_mult ? mult_product : addsub_sum;

    // Scaled operand plus the latched digit
    assign digit_ext = data_t'(digit_q);
    assign entered   = ((state == ADD_DIGIT1) ? operand1 : operand2) + digit_ext;

    // Keys are only taken in the two entry states
    assign busy = (state != ENTER_OP1) && (state != ENTER_OP2);

    always_comb begin
        state_next = state;
        case (state)
            ENTER_OP1: begin
                if (read_input) begin
                    state_next = SCALE_OP1;
                end else if (op_valid) begin
                    state_next = ENTER_OP2;
                end
            end
            SCALE_OP1: begin
                if (mult_finish) begin
                    state_next = ADD_DIGIT1;
                end
            end
            ADD_DIGIT1: state_next = ENTER_OP1;
            ENTER_OP2: begin
                if (read_input) begin
                    state_next = SCALE_OP2;
                end else if (equal_input) begin
                    state_next = START_CALC;
                end
            end
            SCALE_OP2: begin
                if (mult_finish) begin
                    state_next = ADD_DIGIT2;
                end
            end
            ADD_DIGIT2: state_next = ENTER_OP2;
            START_CALC: state_next = WAIT_CALC;
            WAIT_CALC: begin
                if (calc_done) begin
                    state_next = SHOW_RESULT;
                end
            end
            SHOW_RESULT: state_next = ENTER_OP1;
            default:     state_next = ENTER_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_OP1;
            operand1       <= '0;
            operand2       <= '0;
            op_q           <= OP_ADD;
            display_output <= '0;
            complete       <= 1'b0;
            mult_start     <= 1'b0;
            addsub_start   <= 1'b0;
        end else begin
            state        <= state_next;
            complete     <= 1'b0;
            mult_start   <= 1'b0;
            addsub_start <= 1'b0;
            case (state)
                ENTER_OP1: begin
                    if (read_input) begin
                        mult_start <= 1'b1;
                    end else if (op_valid) begin
                        op_q <= operator_input;
                    end
                end
                ENTER_OP2: begin
                    if (read_input) begin
                        mult_start <= 1'b1;
                    end
                end
                SCALE_OP1: begin
                    if (mult_finish) begin
                        operand1 <= mult_product;
                    end
                end
                SCALE_OP2: begin
                    if (mult_finish) begin
                        operand2 <= mult_product;
                    end
                end
                ADD_DIGIT1: begin
                    operand1       <= entered;
                    display_output <= entered;
                end
                ADD_DIGIT2: begin
                    operand2       <= entered;
                    display_output <= entered;
                end
                START_CALC: begin
                    if (use_mult) begin
                        mult_start <= 1'b1;
                    end else begin
                        addsub_start <= 1'b1;
                    end
                end
                SHOW_RESULT: begin
                    display_output <= result;
                    complete       <= 1'b1;
                    // Next calculation starts from zero
                    operand1       <= '0;
                    operand2       <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // Unit operands, loaded together with their start pulse
    always_ff @(posedge clk) begin
        case (state)
            ENTER_OP1: begin
                if (read_input) begin
                    digit_q <= keypad_input;
                    mult_a  <= operand1;
                    mult_b  <= DIGIT_BASE;
                end
            end
            ENTER_OP2: begin
                if (read_input) begin
                    digit_q <= keypad_input;
                    mult_a  <= operand2;
                    mult_b  <= DIGIT_BASE;
                end
            end
            START_CALC: begin
                if (use_mult) begin
                    mult_a <= operand1;
                    mult_b <= operand2;
                end else begin
                    addsub_a   <= operand1;
                    addsub_b   <= operand2;
                    addsub_sub <= (op_q == OP_SUB);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* calculator_top.sv */
// Calculator top level joining the controller, adder/subtractor and multiplier
module calculator_top import calc_pkg::*; (
    input  logic   clk,
    input  logic   nRST,
    input  digit_t keypad_input,
    input  logic   read_input,
    input  op_t    operator_input,
    input  logic   equal_input,
    output data_t  display_output,
    output logic   complete,
    output logic   busy
);

    data_t mult_a;
    data_t mult_b;
    data_t mult_product;
    logic  mult_start;
    logic  mult_finish;
    data_t addsub_a;
    data_t addsub_b;
    data_t addsub_sum;
    logic  addsub_sub;
    logic  addsub_start;
    logic  addsub_finish;

    calc_controller u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .mult_product   (mult_product),
        .mult_finish    (mult_finish),
        .addsub_sum     (addsub_sum),
        .addsub_finish  (addsub_finish),
        .mult_a         (mult_a),
        .mult_b         (mult_b),
        .mult_start     (mult_start),
        .addsub_a       (addsub_a),
        .addsub_b       (addsub_b),
        .addsub_sub     (addsub_sub),
        .addsub_start   (addsub_start),
        .display_output (display_output),
        .complete       (complete),
        .busy           (busy)
    );

    serial_add_sub u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .a      (addsub_a),
        .b      (addsub_b),
        .sub    (addsub_sub),
        .start  (addsub_start),
        .sum    (addsub_sum),
        .finish (addsub_finish)
    );

    seq_multiplier u_mult (
        .clk     (clk),
        .nRST    (nRST),
        .a       (mult_a),
        .b       (mult_b),
        .start   (mult_start),
        .product (mult_product),
        .finish  (mult_finish)
    );

endmodule

/* calc_controller_sva.sv */
// Handshake and pulse assertions for the calculator controller
module calc_controller_sva import calc_pkg::*; (
    input logic        clk,
    input logic        nRST,
    input ctrl_state_t state,
    input logic        mult_start,
    input logic        mult_finish,
    input logic        addsub_start,
    input logic        addsub_finish,
    input logic        complete
);

    a_mult_start_pulse: assert property (@(posedge clk) disable iff (!nRST)
        mult_start |=> !mult_start) else $error("mult_start longer than one cycle");

    a_addsub_start_pulse: assert property (@(posedge clk) disable iff (!nRST)
        addsub_start |=> !addsub_start) else $error("addsub_start longer than one cycle");

    // No restart until the running unit reports finish
    a_mult_busy: assert property (@(posedge clk) disable iff (!nRST)
        mult_start |=> (!mult_start throughout mult_finish[->1]))
        else $error("mult_start issued while the multiplier was running");

    a_addsub_busy: assert property (@(posedge clk) disable iff (!nRST)
        addsub_start |=> (!addsub_start throughout addsub_finish[->1]))
        else $error("addsub_start issued while the adder was running");

    a_mult_latency: assert property (@(posedge clk) disable iff (!nRST)
        mult_start |=> !mult_finish [*16] ##1 mult_finish)
        else $error("mult_finish not 17 cycles after mult_start");

    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete) else $error("complete longer than one cycle");

    // A unit finish only lands while the FSM is waiting for one
    a_finish_awaited: assert property (@(posedge clk) disable iff (!nRST)
        (mult_finish || addsub_finish) |-> state inside {SCALE_OP1, SCALE_OP2, WAIT_CALC})
        else $error("unit finish while the controller was not waiting");

endmodule

/* tb_calculator.sv */
// Calculator testbench with file-driven keypad stimulus, result checks and a watchdog
module tb_calculator import calc_pkg::*; ();

    logic   clk;
    logic   nRST;
    digit_t keypad_input;
    logic   read_input;
    op_t    operator_input;
    logic   equal_input;
    data_t  display_output;
    logic   complete;
    logic   busy;

    int  q_op1[$];
    int  q_op[$];
    int  q_op2[$];
    int  q_expected[$];
    int  n_tests;
    int  errors;
    bit  tests_loaded;
    op_t bad_codes[4] = '{3'b011, 3'b101, 3'b110, 3'b111};

    calculator_top u_dut (.*);

    bind calc_controller calc_controller_sva u_sva (
        .clk           (clk),
        .nRST          (nRST),
        .state         (state),
        .mult_start    (mult_start),
        .mult_finish   (mult_finish),
        .addsub_start  (addsub_start),
        .addsub_finish (addsub_finish),
        .complete      (complete)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Called on a falling edge; idles a random 0 to 3 cycles once keys are taken
    task automatic wait_ready();
        while (busy) begin
            @(negedge clk);
        end
        repeat ($urandom % 4) begin
            @(negedge clk);
        end
    endtask

    task automatic type_digit(input int d, inout int value);
        int cycles;
        wait_ready();
        keypad_input = digit_t'(d);
        read_input   = 1'b1;
        @(posedge clk);
        @(negedge clk);
        read_input = 1'b0;
        cycles = 0;
        while (busy) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        value = (value * 10 + d) % 65536;
        check_value("digit latency", 19, cycles);
        check_value("display_output", value, display_output);
    endtask

    task automatic strobe_operator(input op_t code, input int shown);
        wait_ready();
        operator_input = code;
        @(posedge clk);
        @(negedge clk);
        operator_input = '0;
        check_value("busy", 0, busy);
        check_value("display_output", shown, display_output);
    endtask

    task automatic type_operand(input int operand, input op_t bad_code, output int value);
        int digits[$];
        int rest;
        rest  = operand;
        value = 0;
        do begin
            digits.push_front(rest % 10);
            rest = rest / 10;
        end while (rest > 0);
        foreach (digits[i]) begin
            type_digit(digits[i], value);
            // Invalid code after the first digit, entry must carry on
            if (i == 0 && bad_code != '0) begin
                strobe_operator(bad_code, value);
            end
        end
    endtask

    task automatic press_equals(input int expected, input int latency);
        int cycles;
        wait_ready();
        equal_input = 1'b1;
        @(posedge clk);
        @(negedge clk);
        equal_input = 1'b0;
        cycles = 0;
        while (!complete) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        check_value("complete latency", latency, cycles);
        check_value("display_output", expected, display_output);
        check_value("busy", 0, busy);
        @(negedge clk);
        check_value("complete", 0, complete);
    endtask

    initial begin
        int    fd;
        int    op1;
        int    code;
        int    op2;
        int    expected;
        int    value;
        int    errors_before;
        int    passed;
        int    failed;
        string line;
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        errors         = 0;
        passed         = 0;
        failed         = 0;
        void'($urandom(25));

        fd = $fopen("calculator_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open calculator_tests.txt for reading");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line[0] != "#"
                    && $sscanf(line, "%d %d %d %d", op1, code, op2, expected) == 4) begin
                    q_op1.push_back(op1);
                    q_op.push_back(code);
                    q_op2.push_back(op2);
                    q_expected.push_back(expected);
                end
            end
            $fclose(fd);
        end
        n_tests      = q_op1.size();
        tests_loaded = 1'b1;

        repeat (2) @(negedge clk);
        nRST = 1'b1;
        errors_before = errors;
        check_value("display_output", 0, display_output);
        check_value("complete", 0, complete);
        check_value("busy", 0, busy);
        $display("reset: %s", (errors == errors_before) ? "ok" : "FAILED");

        foreach (q_op1[t]) begin
            errors_before = errors;
            type_operand(q_op1[t], bad_codes[t % 4], value);
            strobe_operator(op_t'(q_op[t]), value);
            type_operand(q_op2[t], '0, value);
            press_equals(q_expected[t], (q_op[t] == int'(OP_MUL)) ? 20 : 8);
            if (errors == errors_before) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test %0d: %0d op%0d %0d -> %0d %s", t, q_op1[t], q_op[t], q_op2[t],
                     q_expected[t], (errors == errors_before) ? "ok" : "FAILED");
        end

        $display("Passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (tests_loaded);
        repeat (n_tests * 400) @(posedge clk);
        $display("Timeout: calculator still running after %0d cycles", n_tests * 400);
        $display("Test failed");
        $finish;
    end

endmodule

/* calculator_tests.txt */
# operand1 operator operand2 expected, all decimal
# operator 1 add, 2 subtract, 4 multiply; results wrap modulo 65536
12 1 34 46
0 1 0 0
999 1 1 1000
65535 1 1 0
40000 1 30000 4464
65535 1 65535 65534
123 2 23 100
5 2 9 65532
0 2 1 65535
100 2 30000 35636
50000 2 12345 37655
7 2 7 0
6 4 7 42
255 4 255 65025
256 4 256 0
1000 4 1000 16960
12345 4 6789 55197
0 4 54321 0
65535 4 65535 1
3 4 21845 65535
9 1 9 18
4321 2 1234 3087
300 4 300 24464
32768 1 32768 0
1 2 65535 2
77 4 0 0
10 4 6553 65530
60000 1 5535 65535
2 4 32768 0
511 4 129 383

/* calculator_top.f */
calc_pkg.sv
serial_add_sub.sv
seq_multiplier.sv
calc_controller.sv
calculator_top.sv
calc_controller_sva.sv
tb_calculator.sv

/* Bender.yml */
package:
  name: calculator

sources:
  - calc_pkg.sv
  - serial_add_sub.sv
  - seq_multiplier.sv
  - calc_controller.sv
  - calculator_top.sv
  - target: test
    files:
      - calc_controller_sva.sv
      - tb_calculator.sv
